/* design/monoPkg.sv */
package monoPkg;

    localparam int NumFlavors = 4;  // Pmos, PmosDpw, Comp, Hv
    localparam int NumCols    = 8;
    localparam int ColBits    = 3;
    localparam int RowBits    = 6;
    localparam int BcidBits   = 6;
    localparam int SeqBits    = 9;
    localparam int WordBits   = 16;
    localparam int ConfBits   = 62;

    // Configuration word layout, LSB first
    localparam int EnFlavorLsb      = 0;
    localparam int EnTestPatternLsb = 4;
    localparam int EnOutLsb         = 8;
    localparam int EnHitOrLsb       = 12;
    localparam int ColMaskLsb       = 16;  // Flavour-major, 1 = masked
    localparam int ColPulseSelLsb   = 48;
    localparam int InjRowLsb        = 56;

    // All flavours on, outputs and hit-or enabled, nothing masked
    localparam logic [ConfBits-1:0] DefaultConf =
        (ConfBits'(4'hF) << EnFlavorLsb) |
        (ConfBits'(4'hF) << EnOutLsb) |
        (ConfBits'(4'hF) << EnHitOrLsb);

    typedef struct packed {
        logic                IsPattern;  // 0 here
        logic [ColBits-1:0]  Col;
        logic [RowBits-1:0]  Row;
        logic [BcidBits-1:0] Ts;
    } hitView_t;

    typedef struct packed {
        logic                IsPattern;  // 1 here
        logic [SeqBits-1:0]  Seq;
        logic [BcidBits-1:0] Ts;
    } patternView_t;

    // One readout word, decoded by its top bit
    typedef union packed {
        hitView_t     Hit;
        patternView_t Pattern;
    } readoutWord_u;

endpackage

/* design/confReg.sv */
`timescale 1ns/1ps

module confReg (
    input  logic                         ClkBx,
    input  logic                         reset_ff,
    input  logic                         ConfSi,
    input  logic                         ConfShift,
    input  logic                         ConfLoad,
    input  logic                         DefConf,
    output logic                         ConfSo,
    output logic [monoPkg::ConfBits-1:0] Conf
);
    import monoPkg::*;

    logic [ConfBits-1:0] confChain;
    logic [ConfBits-1:0] confActive;

    // Serial chain, new bit enters at the bottom
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            confChain <= '0;
        end else if (ConfShift) begin
            confChain <= {confChain[ConfBits-2:0], ConfSi};
        end
    end

    assign ConfSo = confChain[ConfBits-1];  // Top bit straight out

    // Load latch copies the whole chain at once
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            confActive <= '0;
        end else if (ConfLoad) begin
            confActive <= confChain;
        end
    end

    // Default set overrides whatever is loaded
    assign Conf = DefConf ? DefaultConf : confActive;

endmodule

/* design/hitFrontEnd.sv */
`timescale 1ns/1ps

module hitFrontEnd (
    input  logic                                                  ClkBx,
    input  logic                                                  reset_ff,
    input  logic                                                  ResetBcid,
    input  logic                                                  Pulse,
    input  logic [monoPkg::NumFlavors-1:0][monoPkg::NumCols-1:0]  HitStrobe,
    input  logic [monoPkg::NumFlavors-1:0][monoPkg::RowBits-1:0]  HitRow,
    input  logic [monoPkg::ConfBits-1:0]                          Conf,
    output logic [monoPkg::BcidBits-1:0]                          Bcid,
    output logic [monoPkg::NumFlavors-1:0][monoPkg::NumCols-1:0]  ColHit,
    output logic [monoPkg::NumFlavors-1:0][monoPkg::NumCols-1:0]
                 [monoPkg::RowBits-1:0]                           ColRow,
    output logic [monoPkg::NumFlavors-1:0]                        HitOr
);
    import monoPkg::*;

    logic                                 resetBcidQ;
    logic [BcidBits-1:0]                  bcidBin;
    logic [NumFlavors-1:0]                enFlavor;
    logic [NumFlavors-1:0]                enHitOr;
    logic [NumFlavors-1:0][NumCols-1:0]   colMask;
    logic [NumCols-1:0]                   colPulseSel;
    logic [RowBits-1:0]                   injRow;
    logic [NumCols-1:0]                   injCol;

    assign enFlavor    = Conf[EnFlavorLsb +: NumFlavors];
    assign enHitOr     = Conf[EnHitOrLsb +: NumFlavors];
    assign colMask     = Conf[ColMaskLsb +: NumFlavors * NumCols];
    assign colPulseSel = Conf[ColPulseSelLsb +: NumCols];
    assign injRow      = Conf[InjRowLsb +: RowBits];

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            resetBcidQ <= 1'b0;
        end else begin
            resetBcidQ <= ResetBcid;
        end
    end

    // Free-running bunch crossing count
    always_ff @(posedge ClkBx) begin
        if (reset_ff || resetBcidQ) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;
        end
    end

    assign Bcid = (bcidBin >> 1) ^ bcidBin;  // Gray code

    assign injCol = {NumCols{Pulse}} & colPulseSel;

    // Injection shares the column with the sensor hit and wins the row
    always_comb begin
        for (int f = 0; f < NumFlavors; f++) begin
            for (int c = 0; c < NumCols; c++) begin
                ColHit[f][c] = enFlavor[f] & ~colMask[f][c] & (HitStrobe[f][c] | injCol[c]);
                ColRow[f][c] = injCol[c] ? injRow : HitRow[f];
            end
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            HitOr <= '0;
        end else begin
            for (int f = 0; f < NumFlavors; f++) begin
                HitOr[f] <= enHitOr[f] & (|ColHit[f]);
            end
        end
    end

endmodule

/* design/columnReadout.sv */
`timescale 1ns/1ps

module columnReadout (
    input  logic                                               ClkBx,
    input  logic                                               reset_ff,
    input  logic                                               Freeze,
    input  logic                                               Read,
    input  logic                                               EnOut,
    input  logic                                               EnTestPattern,
    input  logic [monoPkg::BcidBits-1:0]                       Bcid,
    input  logic [monoPkg::NumCols-1:0]                        ColHit,
    input  logic [monoPkg::NumCols-1:0][monoPkg::RowBits-1:0]  ColRow,
    output logic                                               Token,
    output monoPkg::readoutWord_u                              DataOut
);
    import monoPkg::*;

    logic [NumCols-1:0]                colFull;
    logic [NumCols-1:0][RowBits-1:0]   colRowQ;
    logic [NumCols-1:0][BcidBits-1:0]  colTsQ;
    logic [SeqBits-1:0]                seqCnt;
    logic [ColBits-1:0]                selCol;
    logic                              anyFull;
    logic                              readFire;
    logic [NumCols-1:0]                colStore;

    // Lowest full column wins
    always_comb begin
        selCol = '0;
        for (int c = NumCols - 1; c >= 0; c--) begin
            if (colFull[c]) begin
                selCol = ColBits'(c);
            end
        end
    end

    assign anyFull  = |colFull;
    assign Token    = Freeze & EnOut & (EnTestPattern | anyFull);
    assign readFire = Read & Token;

    // Empty, unfrozen columns take the new hit
    assign colStore = ColHit & ~colFull & {NumCols{~Freeze}};

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            colFull <= '0;
        end else begin
            for (int c = 0; c < NumCols; c++) begin
                if (colStore[c]) begin
                    colFull[c] <= 1'b1;
                end else if (readFire && !EnTestPattern && selCol == ColBits'(c)) begin
                    colFull[c] <= 1'b0;  // Read empties it
                end
            end
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            colRowQ <= '0;
            colTsQ  <= '0;
        end else begin
            for (int c = 0; c < NumCols; c++) begin
                if (colStore[c]) begin
                    colRowQ[c] <= ColRow[c];
                    colTsQ[c]  <= Bcid;
                end
            end
        end
    end

    // Output word lands one cycle after Read
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            DataOut <= {WordBits{1'b0}};
            seqCnt  <= '0;
        end else if (readFire) begin
            if (EnTestPattern) begin
                // Pattern reads leave the latches alone
                DataOut.Pattern.IsPattern <= 1'b1;
                DataOut.Pattern.Seq       <= seqCnt;
                DataOut.Pattern.Ts        <= Bcid;
                seqCnt                    <= seqCnt + 1'b1;
            end else begin
                DataOut.Hit.IsPattern <= 1'b0;
                DataOut.Hit.Col       <= selCol;
                DataOut.Hit.Row       <= colRowQ[selCol];
                DataOut.Hit.Ts        <= colTsQ[selCol];
            end
        end
    end

endmodule

/* design/monoTop.sv */
`timescale 1ns/1ps

module monoTop (
    input  logic                                                  ClkBx,
    input  logic                                                  reset_ff,
    input  logic                                                  ConfSi,
    input  logic                                                  ConfShift,
    input  logic                                                  ConfLoad,
    input  logic                                                  DefConf,
    input  logic                                                  ResetBcid,
    input  logic                                                  Pulse,
    input  logic [monoPkg::NumFlavors-1:0][monoPkg::NumCols-1:0]  HitStrobe,
    input  logic [monoPkg::NumFlavors-1:0][monoPkg::RowBits-1:0]  HitRow,
    input  logic [monoPkg::NumFlavors-1:0]                        Freeze,
    input  logic [monoPkg::NumFlavors-1:0]                        Read,
    output logic                                                  ConfSo,
    output logic [monoPkg::NumFlavors-1:0]                        Token,
    output monoPkg::readoutWord_u [monoPkg::NumFlavors-1:0]       DataOut,
    output logic [monoPkg::NumFlavors-1:0]                        HitOr
);
    import monoPkg::*;

    logic [ConfBits-1:0]                            conf;
    logic [BcidBits-1:0]                            bcid;
    logic [NumFlavors-1:0][NumCols-1:0]             colHit;
    logic [NumFlavors-1:0][NumCols-1:0][RowBits-1:0] colRow;

    confReg uConfReg (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ConfSi    (ConfSi),
        .ConfShift (ConfShift),
        .ConfLoad  (ConfLoad),
        .DefConf   (DefConf),
        .ConfSo    (ConfSo),
        .Conf      (conf)
    );

    hitFrontEnd uFrontEnd (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ResetBcid (ResetBcid),
        .Pulse     (Pulse),
        .HitStrobe (HitStrobe),
        .HitRow    (HitRow),
        .Conf      (conf),
        .Bcid      (bcid),
        .ColHit    (colHit),
        .ColRow    (colRow),
        .HitOr     (HitOr)
    );

    // One readout per flavour
    // Index 0 Pmos, 1 PmosDpw, 2 Comp, 3 Hv
    for (genvar f = 0; f < NumFlavors; f++) begin : gReadout
        columnReadout uReadout (
            .ClkBx         (ClkBx),
            .reset_ff      (reset_ff),
            .Freeze        (Freeze[f]),
            .Read          (Read[f]),
            .EnOut         (conf[EnOutLsb + f]),
            .EnTestPattern (conf[EnTestPatternLsb + f]),
            .Bcid          (bcid),
            .ColHit        (colHit[f]),
            .ColRow        (colRow[f]),
            .Token         (Token[f]),
            .DataOut       (DataOut[f])
        );
    end

endmodule

/* tb/monoModel.svh */
`ifndef MONO_MODEL_SVH
`define MONO_MODEL_SVH

// Reference state, advanced once per rising edge
logic [ConfBits-1:0]                              mChain;
logic [ConfBits-1:0]                              mConf;
logic                                             mRstQ;
logic [BcidBits-1:0]                              mBin;
logic [NumFlavors-1:0][NumCols-1:0]               mFull;
logic [NumFlavors-1:0][NumCols-1:0][RowBits-1:0]  mRow;
logic [NumFlavors-1:0][NumCols-1:0][BcidBits-1:0] mTs;
logic [NumFlavors-1:0][SeqBits-1:0]               mSeq;
readoutWord_u [NumFlavors-1:0]                    mData;
logic [NumFlavors-1:0]                            mHitOr;

function automatic logic [BcidBits-1:0] grayOf(input logic [BcidBits-1:0] bin);
    return bin ^ (bin >> 1);
endfunction

function automatic logic [ConfBits-1:0] makeConf(
    input logic [NumFlavors-1:0]         enFlavor,
    input logic [NumFlavors-1:0]         enTestPattern,
    input logic [NumFlavors-1:0]         enOut,
    input logic [NumFlavors-1:0]         enHitOr,
    input logic [NumFlavors*NumCols-1:0] colMask,
    input logic [NumCols-1:0]            colPulseSel,
    input logic [RowBits-1:0]            injRow
);
    logic [ConfBits-1:0] c;
    c = '0;
    c[EnFlavorLsb +: NumFlavors]       = enFlavor;
    c[EnTestPatternLsb +: NumFlavors]  = enTestPattern;
    c[EnOutLsb +: NumFlavors]          = enOut;
    c[EnHitOrLsb +: NumFlavors]        = enHitOr;
    c[ColMaskLsb +: NumFlavors*NumCols] = colMask;
    c[ColPulseSelLsb +: NumCols]       = colPulseSel;
    c[InjRowLsb +: RowBits]            = injRow;
    return c;
endfunction

// Configuration in force this cycle
function automatic logic [ConfBits-1:0] effConf();
    if (defConf) begin
        return makeConf('1, '0, '1, '1, '0, '0, '0);
    end
    return mConf;
endfunction

function automatic logic modelToken(input int f);
    logic [ConfBits-1:0] c;
    c = effConf();
    return freeze[f] & c[EnOutLsb + f] & (c[EnTestPatternLsb + f] | (|mFull[f]));
endfunction

task automatic modelReset();
    mChain = '0;
    mConf  = '0;
    mRstQ  = 1'b0;
    mBin   = '0;
    mFull  = '0;
    mRow   = '0;
    mTs    = '0;
    mSeq   = '0;
    mData  = '0;
    mHitOr = '0;
endtask

task automatic modelEdge();
    logic [ConfBits-1:0]             c;
    logic [NumCols-1:0]              hit;
    logic [NumCols-1:0]              injCol;
    logic [NumCols-1:0][RowBits-1:0] rowIn;
    logic                            tok;
    int                              sel;
    readoutWord_u                    w;
    c = effConf();
    for (int f = 0; f < NumFlavors; f++) begin
        tok = modelToken(f);
        for (int k = 0; k < NumCols; k++) begin
            injCol[k] = pulse & c[ColPulseSelLsb + k];
            hit[k] = c[EnFlavorLsb + f] & ~c[ColMaskLsb + f * NumCols + k]
                & (hitStrobe[f][k] | injCol[k]);
            rowIn[k] = injCol[k] ? c[InjRowLsb +: RowBits] : hitRow[f];
        end
        mHitOr[f] = c[EnHitOrLsb + f] & (|hit);
        if (read[f] && tok) begin
            w = '0;
            if (c[EnTestPatternLsb + f]) begin
                w.Pattern.IsPattern = 1'b1;
                w.Pattern.Seq       = mSeq[f];
                w.Pattern.Ts        = grayOf(mBin);
                mSeq[f] = mSeq[f] + SeqBits'(1);
            end else begin
                sel = 0;
                while (sel < NumCols - 1 && !mFull[f][sel]) sel++;
                w.Hit.Col = ColBits'(sel);
                w.Hit.Row = mRow[f][sel];
                w.Hit.Ts  = mTs[f][sel];
                mFull[f][sel] = 1'b0;
            end
            mData[f] = w;
        end
        if (!freeze[f]) begin
            for (int k = 0; k < NumCols; k++) begin
                if (hit[k] && !mFull[f][k]) begin  // Full column drops the hit
                    mFull[f][k] = 1'b1;
                    mRow[f][k]  = rowIn[k];
                    mTs[f][k]   = grayOf(mBin);
                end
            end
        end
    end
    if (confLoad) mConf = mChain;
    if (confShift) mChain = {mChain[ConfBits-2:0], confSi};
    mBin  = mRstQ ? '0 : mBin + BcidBits'(1);
    mRstQ = resetBcid;
endtask

`endif

/* tb/monoTb.sv */
`timescale 1ns/1ps

module monoTb;
    import monoPkg::*;

    logic                               ClkBx;
    logic                               reset_ff;
    logic                               confSi;
    logic                               confShift;
    logic                               confLoad;
    logic                               defConf;
    logic                               resetBcid;
    logic                               pulse;
    logic [NumFlavors-1:0][NumCols-1:0] hitStrobe;
    logic [NumFlavors-1:0][RowBits-1:0] hitRow;
    logic [NumFlavors-1:0]              freeze;
    logic [NumFlavors-1:0]              read;
    logic                               confSo;
    logic [NumFlavors-1:0]              token;
    readoutWord_u [NumFlavors-1:0]      dataOut;
    logic [NumFlavors-1:0]              hitOr;
    integer                             seed = 32'h4a1c_d1d0;

    `include "monoModel.svh"

    monoTop DUT (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ConfSi    (confSi),
        .ConfShift (confShift),
        .ConfLoad  (confLoad),
        .DefConf   (defConf),
        .ResetBcid (resetBcid),
        .Pulse     (pulse),
        .HitStrobe (hitStrobe),
        .HitRow    (hitRow),
        .Freeze    (freeze),
        .Read      (read),
        .ConfSo    (confSo),
        .Token     (token),
        .DataOut   (dataOut),
        .HitOr     (hitOr)
    );

    initial begin
        ClkBx = 1'b0;
        forever #4 ClkBx = ~ClkBx;
    end

    initial begin
        #200_000;
        stopOnError("Simulation ran past its time limit");
    end

    task automatic stopOnError(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stopOnError($sformatf("CHECK FAILED at %0t: %s got %0h expected %0h",
                $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    task automatic checkOutputs();
        checkEq(32'(confSo), 32'(mChain[ConfBits-1]), "ConfSo");
        checkEq(32'(hitOr), 32'(mHitOr), "HitOr");
        for (int f = 0; f < NumFlavors; f++) begin
            checkEq(32'(token[f]), 32'(modelToken(f)), $sformatf("Token[%0d]", f));
            checkEq(32'(dataOut[f]), 32'(mData[f]), $sformatf("DataOut[%0d]", f));
        end
    endtask

    // Runs from just after one falling edge drive to the next falling edge
    task automatic step();
        #1;
        checkOutputs();
        modelEdge();
        @(negedge ClkBx);
    endtask

    task automatic shiftWord(input logic [ConfBits-1:0] word);
        for (int i = ConfBits - 1; i >= 0; i--) begin
            confSi    = word[i];
            confShift = 1'b1;
            step();
        end
        confShift = 1'b0;
    endtask

    task automatic loadConf(input logic [ConfBits-1:0] word);
        shiftWord(word);
        confLoad = 1'b1;
        step();
        confLoad = 1'b0;
    endtask

    task automatic waitToken(input int f, input int limit);
        int n;
        n = 0;
        step();
        while (token[f] !== 1'b1) begin
            if (n == limit) begin
                stopOnError($sformatf("Token of flavour %0d never rose after Freeze", f));
            end
            n++;
            step();
        end
    endtask

    // Read every flavour until no Token is left
    task automatic drain();
        int n;
        n = 0;
        hitStrobe = '0;
        pulse     = 1'b0;
        resetBcid = 1'b0;
        freeze    = '1;
        read      = '1;
        step();
        while (token !== '0) begin
            if (n == 40) begin
                stopOnError("Token stayed high while draining the readouts");
            end
            n++;
            step();
        end
        read   = '0;
        freeze = '0;
        step();
    endtask

    task automatic randomTraffic(input int cycles, input logic [3:0] pulseMask);
        logic [31:0] r;
        logic [31:0] q;
        for (int n = 0; n < cycles; n++) begin
            for (int f = 0; f < NumFlavors; f++) begin
                r = randWord();
                hitStrobe[f] = r[7:0] & r[15:8] & r[23:16];  // Sparse hits
                hitRow[f]    = r[29:24];
                if (r[31:30] == 2'b00 && r[3]) freeze[f] = ~freeze[f];
                read[f] = freeze[f] & r[20];
            end
            q = randWord();
            pulse     = (q[3:0] & pulseMask) == 4'd0;
            resetBcid = q[8:4] == 5'd0;
            step();
        end
        hitStrobe = '0;
        pulse     = 1'b0;
        resetBcid = 1'b0;
        read      = '0;
    endtask

    initial begin
        logic [63:0]         wide;
        logic [ConfBits-1:0] word;
        logic [31:0]         r;
        reset_ff  = 1'b1;
        confSi    = 1'b0;
        confShift = 1'b0;
        confLoad  = 1'b0;
        defConf   = 1'b0;
        resetBcid = 1'b0;
        pulse     = 1'b0;
        hitStrobe = '0;
        hitRow    = '0;
        freeze    = '0;
        read      = '0;
        modelReset();
        repeat (5) @(negedge ClkBx);
        reset_ff = 1'b0;

        // Chain round trip returns the top bit first
        wide = {randWord(), randWord()};
        word = wide[ConfBits-1:0];
        shiftWord(word);
        for (int i = ConfBits - 1; i >= 0; i--) begin
            checkEq(32'(confSo), 32'(word[i]), "ConfSo returning shifted word");
            r = randWord();
            confSi    = r[0];
            confShift = 1'b1;
            step();
        end
        confShift = 1'b0;

        // Default set over a random loaded word
        wide = {randWord(), randWord()};
        loadConf(wide[ConfBits-1:0]);
        defConf   = 1'b1;
        resetBcid = 1'b1;
        step();
        resetBcid = 1'b0;
        randomTraffic(300, 4'hF);
        drain();
        defConf = 1'b0;

        // Timestamps and readout order
        loadConf(makeConf('1, '0, '1, '1, '0, '0, '0));
        resetBcid = 1'b1;
        step();
        resetBcid = 1'b0;
        randomTraffic(400, 4'hF);
        drain();

        // Masks, injection and hit-or
        for (int k = 0; k < 3; k++) begin
            wide = {randWord(), randWord()};
            loadConf(makeConf(wide[3:0], '0, '1, wide[7:4], wide[39:8], wide[47:40],
                wide[53:48]));
            randomTraffic(300, 4'h3);
            drain();
        end

        // Test pattern with empty latches first
        loadConf(makeConf('1, '1, '1, '1, '0, '0, '0));
        freeze = '1;
        for (int f = 0; f < NumFlavors; f++) waitToken(f, 4);
        read = '1;
        repeat (6) step();
        read   = '0;
        freeze = '0;
        randomTraffic(200, 4'hF);
        freeze = '1;
        loadConf(makeConf('1, '0, '1, '1, '0, '0, '0));
        drain();  // Hits kept through the pattern reads

        // Output enables partly off
        r = randWord();
        loadConf(makeConf('1, r[3:0], r[7:4] & 4'b0110, '1, '0, r[15:8], r[21:16]));
        randomTraffic(300, 4'h7);
        freeze = '1;
        loadConf(makeConf('1, '0, '1, '1, '0, '0, '0));
        drain();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+tb
design/monoPkg.sv
design/confReg.sv
design/hitFrontEnd.sv
design/columnReadout.sv
design/monoTop.sv
tb/monoTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary -j 0 -f vlog.f --top-module monoTb -Mdir obj_dir > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/VmonoTb > sim.log 2>&1
grep -qx "RESULT: PASS" sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
